/* hdl/id_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module id_decoder (
  input  logic [id_pkg::XLEN-1:0] instr_rdata_i,
  output id_pkg::decode_t         dec_o,
  output id_pkg::imm_set_t        imm_o
);

  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_rdata_i[6:0];
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  // Sign-extended immediates
  assign imm_o.i = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_o.s = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
  assign imm_o.u = {instr_rdata_i[31:12], 12'b0};

  always_comb begin
    dec_o               = '0;
    dec_o.alu_op        = ALU_ADD;
    dec_o.op_a_sel      = OP_A_REG_A;
    dec_o.op_b_sel      = OP_B_IMM;
    dec_o.imm_sel       = IMM_I;
    dec_o.rf_wd_sel     = RF_WD_EX;
    dec_o.raddr_a       = instr_rdata_i[19:15];
    dec_o.raddr_b       = instr_rdata_i[24:20];
    dec_o.waddr         = instr_rdata_i[11:7];
    dec_o.data_type     = DATA_WORD;

    unique case (opcode)
      OPC_OP: begin
        dec_o.rf_we    = 1'b1;
        dec_o.op_b_sel = OP_B_REG_B;
        if (funct7 == 7'b0000000) begin
          unique case (funct3)
            3'b000:  dec_o.alu_op = ALU_ADD;
            3'b001:  dec_o.alu_op = ALU_SLL;
            3'b010:  dec_o.alu_op = ALU_SLT;
            3'b011:  dec_o.alu_op = ALU_SLTU;
            3'b100:  dec_o.alu_op = ALU_XOR;
            3'b101:  dec_o.alu_op = ALU_SRL;
            3'b110:  dec_o.alu_op = ALU_OR;
            default: dec_o.alu_op = ALU_AND;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          dec_o.alu_op = ALU_SUB;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          dec_o.alu_op = ALU_SRA;
        end else begin
          dec_o.illegal = 1'b1;
        end
      end

      OPC_OP_IMM: begin
        dec_o.rf_we = 1'b1;
        unique case (funct3)
          3'b000:  dec_o.alu_op = ALU_ADD;
          3'b010:  dec_o.alu_op = ALU_SLT;
          3'b011:  dec_o.alu_op = ALU_SLTU;
          3'b100:  dec_o.alu_op = ALU_XOR;
          3'b110:  dec_o.alu_op = ALU_OR;
          3'b111:  dec_o.alu_op = ALU_AND;
          3'b001: begin
            dec_o.alu_op  = ALU_SLL;
            dec_o.illegal = (funct7 != 7'b0000000);
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            dec_o.alu_op  = (funct7 == 7'b0100000) ? ALU_SRA : ALU_SRL;
            dec_o.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        endcase
      end

      OPC_LUI, OPC_AUIPC: begin
        dec_o.rf_we    = 1'b1;
        dec_o.imm_sel  = IMM_U;
        dec_o.op_a_sel = (opcode == OPC_LUI) ? OP_A_ZERO : OP_A_CURRPC;
      end

      OPC_LOAD: begin
        dec_o.rf_we         = 1'b1;
        dec_o.rf_wd_sel     = RF_WD_LSU;
        dec_o.data_req      = 1'b1;
        dec_o.data_sign_ext = ~funct3[2];
        unique case (funct3)
          3'b000, 3'b100: dec_o.data_type = DATA_BYTE;
          3'b001, 3'b101: dec_o.data_type = DATA_HALF;
          3'b010:         dec_o.data_type = DATA_WORD;
          default:        dec_o.illegal   = 1'b1;
        endcase
      end

      OPC_STORE: begin
        dec_o.imm_sel  = IMM_S;
        dec_o.data_req = 1'b1;
        dec_o.data_we  = 1'b1;
        unique case (funct3)
          3'b000:  dec_o.data_type = DATA_BYTE;
          3'b001:  dec_o.data_type = DATA_HALF;
          3'b010:  dec_o.data_type = DATA_WORD;
          default: dec_o.illegal   = 1'b1;
        endcase
      end

      default: dec_o.illegal = 1'b1;
    endcase

    // An illegal instruction must leave no trace
    if (dec_o.illegal) begin
      dec_o.rf_we    = 1'b0;
      dec_o.data_req = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hdl/id_multicycle_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module id_multicycle_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                instr_new_i,
  input  id_pkg::decode_t     dec_i,
  input  logic                lsu_valid_i,
  output logic                rf_we_o,
  output id_pkg::rf_wd_sel_e  rf_wd_sel_o,
  output logic                data_req_o,
  output logic                id_in_ready_o
);

  typedef enum logic {IDLE, WAIT_MULTICYCLE} state_e;

  state_e state_q, state_d;
  logic   instr_multicycle_done_q, instr_multicycle_done_d;
  logic   instr_executing;
  logic   rf_we_fsm;

  //////////////////////////////////////////////////
  // State registers
  //////////////////////////////////////////////////

  // Done starts set so nothing is written before the first instruction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q                 <= IDLE;
      instr_multicycle_done_q <= 1'b1;
    end else begin
      state_q                 <= state_d;
      instr_multicycle_done_q <= instr_multicycle_done_d;
    end
  end

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d                 = state_q;
    instr_multicycle_done_d = instr_multicycle_done_q;
    rf_we_fsm               = dec_i.rf_we;
    id_in_ready_o           = 1'b1;

    unique case (state_q)
      IDLE: begin
        if (instr_new_i) begin
          if (dec_i.data_req) begin
            // Memory access, write back comes with the LSU strobe
            state_d                 = WAIT_MULTICYCLE;
            instr_multicycle_done_d = 1'b0;
            rf_we_fsm               = 1'b0;
            id_in_ready_o           = 1'b0;
          end else begin
            instr_multicycle_done_d = 1'b1;
          end
        end
      end

      WAIT_MULTICYCLE: begin
        if (lsu_valid_i) begin
          state_d                 = IDLE;
          instr_multicycle_done_d = 1'b1;
        end else begin
          rf_we_fsm     = 1'b0;
          id_in_ready_o = 1'b0;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  // Only a new or unfinished instruction may act
  assign instr_executing = instr_new_i | ~instr_multicycle_done_q;

  assign rf_we_o     = instr_executing & rf_we_fsm;
  assign data_req_o  = instr_executing & dec_i.data_req;
  assign rf_wd_sel_o = dec_i.rf_wd_sel;

endmodule

`default_nettype wire

/* hdl/id_operand_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module id_operand_mux (
  input  id_pkg::decode_t          dec_i,
  input  id_pkg::imm_set_t         imm_i,
  input  logic [id_pkg::XLEN-1:0]  rdata_a_i,
  input  logic [id_pkg::XLEN-1:0]  rdata_b_i,
  input  logic [id_pkg::XLEN-1:0]  pc_i,
  output id_pkg::ex_req_t          ex_o
);

  import id_pkg::*;

  logic [XLEN-1:0] imm_val;

  // Immediate select
  always_comb begin
    unique case (dec_i.imm_sel)
      IMM_S:   imm_val = imm_i.s;
      IMM_U:   imm_val = imm_i.u;
      default: imm_val = imm_i.i;
    endcase
  end

  // Operand A, pc for AUIPC and zero for LUI
  always_comb begin
    unique case (dec_i.op_a_sel)
      OP_A_CURRPC: ex_o.operand_a = pc_i;
      OP_A_ZERO:   ex_o.operand_a = '0;
      default:     ex_o.operand_a = rdata_a_i;
    endcase
  end

  // Loads and stores route their offset here, the ALU adds the base
  assign ex_o.operand_b = (dec_i.op_b_sel == OP_B_IMM) ? imm_val : rdata_b_i;
  assign ex_o.alu_op    = dec_i.alu_op;

endmodule

`default_nettype wire

/* hdl/id_pkg.sv */
`default_nettype none

package id_pkg;

  //////////////////////////////////////////////////
  // Widths and opcodes
  //////////////////////////////////////////////////

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;

  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;

  // Access size as seen by the LSU
  localparam logic [1:0] DATA_WORD = 2'b00;
  localparam logic [1:0] DATA_HALF = 2'b01;
  localparam logic [1:0] DATA_BYTE = 2'b10;

  //////////////////////////////////////////////////
  // Selector enums
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;
  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U} imm_sel_e;
  typedef enum logic {RF_WD_EX, RF_WD_LSU} rf_wd_sel_e;

  //////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                  illegal;
    alu_op_e               alu_op;
    op_a_sel_e             op_a_sel;
    op_b_sel_e             op_b_sel;
    imm_sel_e              imm_sel;
    logic                  rf_we;
    rf_wd_sel_e            rf_wd_sel;
    logic [REG_ADDR_W-1:0] raddr_a;
    logic [REG_ADDR_W-1:0] raddr_b;
    logic [REG_ADDR_W-1:0] waddr;
    logic                  data_req;
    logic                  data_we;
    logic [1:0]            data_type;
    logic                  data_sign_ext;
  } decode_t;

  typedef struct packed {
    logic [XLEN-1:0] i;
    logic [XLEN-1:0] s;
    logic [XLEN-1:0] u;
  } imm_set_t;

  typedef struct packed {
    alu_op_e         alu_op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
  } ex_req_t;

  typedef struct packed {
    logic            req;
    logic            we;
    logic [1:0]      data_type;
    logic            sign_ext;
    logic [XLEN-1:0] wdata;
  } lsu_req_t;

endpackage

`default_nettype wire

/* hdl/id_register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module id_register_file (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [id_pkg::REG_ADDR_W-1:0]  raddr_a_i,
  input  logic [id_pkg::REG_ADDR_W-1:0]  raddr_b_i,
  input  logic [id_pkg::REG_ADDR_W-1:0]  waddr_i,
  input  logic [id_pkg::XLEN-1:0]        wdata_i,
  input  logic                           we_i,
  output logic [id_pkg::XLEN-1:0]        rdata_a_o,
  output logic [id_pkg::XLEN-1:0]        rdata_b_o
);

  import id_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] rf_q [NUM_REGS-1:1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 1; i < NUM_REGS; i++) begin
        rf_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      rf_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : rf_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : rf_q[raddr_b_i];

endmodule

`default_nettype wire

/* hdl/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     instr_new_i,
  input  logic [id_pkg::XLEN-1:0]  instr_rdata_i,
  input  logic [id_pkg::XLEN-1:0]  pc_id_i,
  input  logic                     lsu_valid_i,
  input  logic [id_pkg::XLEN-1:0]  regfile_wdata_ex_i,
  input  logic [id_pkg::XLEN-1:0]  regfile_wdata_lsu_i,
  output logic                     id_in_ready_o,
  output logic                     illegal_insn_o,
  output id_pkg::ex_req_t          ex_o,
  output id_pkg::lsu_req_t         lsu_o
);

  import id_pkg::*;

  decode_t         dec;
  imm_set_t        imm_set;
  logic [XLEN-1:0] rdata_a;
  logic [XLEN-1:0] rdata_b;
  logic [XLEN-1:0] rf_wdata;
  logic            rf_we;
  rf_wd_sel_e      rf_wd_sel;
  logic            data_req;

  id_decoder decoder_i (
    .instr_rdata_i (instr_rdata_i),
    .dec_o         (dec),
    .imm_o         (imm_set)
  );

  //////////////////////////////////////////////////
  // Register file and write back
  //////////////////////////////////////////////////

  assign rf_wdata = (rf_wd_sel == RF_WD_LSU) ? regfile_wdata_lsu_i : regfile_wdata_ex_i;

  id_register_file register_file_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (dec.raddr_a),
    .raddr_b_i (dec.raddr_b),
    .waddr_i   (dec.waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  id_operand_mux operand_mux_i (
    .dec_i     (dec),
    .imm_i     (imm_set),
    .rdata_a_i (rdata_a),
    .rdata_b_i (rdata_b),
    .pc_i      (pc_id_i),
    .ex_o      (ex_o)
  );

  id_multicycle_ctrl multicycle_ctrl_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_new_i   (instr_new_i),
    .dec_i         (dec),
    .lsu_valid_i   (lsu_valid_i),
    .rf_we_o       (rf_we),
    .rf_wd_sel_o   (rf_wd_sel),
    .data_req_o    (data_req),
    .id_in_ready_o (id_in_ready_o)
  );

  //////////////////////////////////////////////////
  // LSU request
  //////////////////////////////////////////////////

  // Store data always comes from read port B
  assign lsu_o.req       = data_req;
  assign lsu_o.we        = dec.data_we;
  assign lsu_o.data_type = dec.data_type;
  assign lsu_o.sign_ext  = dec.data_sign_ext;
  assign lsu_o.wdata     = rdata_b;

  assign illegal_insn_o = dec.illegal;

endmodule

`default_nettype wire

/* project.f */
hdl/id_pkg.sv
hdl/id_decoder.sv
hdl/id_register_file.sv
hdl/id_operand_mux.sv
hdl/id_multicycle_ctrl.sv
hdl/id_stage.sv
sim/id_stage_assertions.sv
sim/tb_id_stage.sv

/* sim/id_stage_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage_assertions (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             lsu_valid_i,
  input logic             ready_i,
  input logic             illegal_i,
  input id_pkg::lsu_req_t lsu_i
);

  int unsigned failures = 0;

  // Controller leaves reset in IDLE
  ready_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> ready_i)
    else begin
      $error("id_in_ready_o low in the first cycle after reset");
      failures++;
    end

  no_req_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !lsu_i.req)
    else begin
      $error("lsu_o.req high during reset");
      failures++;
    end

  // Request held until the done strobe
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lsu_i.req && !lsu_valid_i) |=> lsu_i.req)
    else begin
      $error("lsu_o.req dropped before lsu_valid_i");
      failures++;
    end

  illegal_no_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    illegal_i |-> !lsu_i.req)
    else begin
      $error("Illegal instruction raised lsu_o.req");
      failures++;
    end

endmodule

`default_nettype wire

/* sim/id_testdata.mem */
// instr pc wb_value exp_op_a exp_op_b alu_op req_we store_data illegal
// req_we is 2 for a load and 3 for a store, alu_op uses the alu_op_e encoding
002081B3 00000100 00000000 00000000 00000000 0 0 00000000 0
12300093 00000104 00000123 00000000 00000123 0 0 00000000 0
FFB08113 00000108 0000011E 00000123 FFFFFFFB 0 0 00000000 0
ABCDE237 0000010C ABCDE000 00000000 ABCDE000 0 0 00000000 0
00012297 00000110 00012110 00000110 00012000 0 0 00000000 0
0FF24013 00000114 DEADBEEF ABCDE000 000000FF 2 0 00000000 0
40500333 00000118 FFFEDEF0 00000000 00012110 1 0 00000000 0
0080A383 0000011C CAFEF00D 00000123 00000008 0 2 00000000 0
FE712E23 00000120 55555555 0000011E FFFFFFFC 0 3 CAFEF00D 0
0000008B 00000124 BAD0BAD0 00000000 00000000 0 0 00000000 1
01C08433 00000128 00000123 00000123 00000000 0 0 00000000 0
007364B3 0000012C FFFEFEFD FFFEDEF0 CAFEF00D 3 0 00000000 0

/* sim/tb_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

  import id_pkg::*;

  localparam int unsigned CLK_PERIOD     = 8;
  localparam int unsigned RESET_CYCLES   = 5;
  localparam int unsigned NUM_VECS       = 12;
  localparam int unsigned VEC_WORDS      = 9;
  localparam int unsigned TIMEOUT_CYCLES = 20;

  logic            clk_i;
  logic            rst_ni;
  logic            instr_new_i;
  logic [XLEN-1:0] instr_rdata_i;
  logic [XLEN-1:0] pc_id_i;
  logic            lsu_valid_i;
  logic [XLEN-1:0] regfile_wdata_ex_i;
  logic [XLEN-1:0] regfile_wdata_lsu_i;
  logic            id_in_ready_o;
  logic            illegal_insn_o;
  ex_req_t         ex_o;
  lsu_req_t        lsu_o;

  // One word per column, VEC_WORDS columns per vector
  logic [XLEN-1:0] vec_mem [NUM_VECS*VEC_WORDS];
  integer          seed;

  id_stage id_stage_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_new_i         (instr_new_i),
    .instr_rdata_i       (instr_rdata_i),
    .pc_id_i             (pc_id_i),
    .lsu_valid_i         (lsu_valid_i),
    .regfile_wdata_ex_i  (regfile_wdata_ex_i),
    .regfile_wdata_lsu_i (regfile_wdata_lsu_i),
    .id_in_ready_o       (id_in_ready_o),
    .illegal_insn_o      (illegal_insn_o),
    .ex_o                (ex_o),
    .lsu_o               (lsu_o)
  );

  bind id_stage id_stage_assertions assertions_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lsu_valid_i (lsu_valid_i),
    .ready_i     (id_in_ready_o),
    .illegal_i   (illegal_insn_o),
    .lsu_i       (lsu_o)
  );

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [XLEN-1:0] actual,
                             input logic [XLEN-1:0] expected);
    string msg;
    if (actual !== expected) begin
      msg = $sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
      abort_run(msg);
    end
  endtask

  // Access size from funct3[1:0] of a load or store
  function automatic logic [1:0] size_from_funct3(input logic [1:0] size_bits);
    case (size_bits)
      2'b00:   return DATA_BYTE;
      2'b01:   return DATA_HALF;
      default: return DATA_WORD;
    endcase
  endfunction

  // Present one vector, check the decode and model the LSU strobe
  task automatic run_vector(input int unsigned idx);
    logic [XLEN-1:0] instr, pc, wb_val, exp_a, exp_b, exp_wdata;
    alu_op_e         exp_alu;
    logic            exp_req, exp_we, exp_illegal;
    int unsigned     base, latency, cycles;
    base        = idx * VEC_WORDS;
    instr       = vec_mem[base];
    pc          = vec_mem[base+1];
    wb_val      = vec_mem[base+2];
    exp_a       = vec_mem[base+3];
    exp_b       = vec_mem[base+4];
    exp_alu     = alu_op_e'(vec_mem[base+5][3:0]);
    exp_req     = vec_mem[base+6][1];
    exp_we      = vec_mem[base+6][0];
    exp_wdata   = vec_mem[base+7];
    exp_illegal = vec_mem[base+8][0];

    @(negedge clk_i);
    instr_new_i         = 1'b1;
    instr_rdata_i       = instr;
    pc_id_i             = pc;
    regfile_wdata_ex_i  = wb_val;
    regfile_wdata_lsu_i = '0;
    #(CLK_PERIOD/4);
    check_value("illegal_insn_o", illegal_insn_o, exp_illegal);
    if (!exp_illegal) begin
      check_value("operand_a", ex_o.operand_a, exp_a);
      check_value("operand_b", ex_o.operand_b, exp_b);
      check_value("alu_op", ex_o.alu_op, exp_alu);
    end
    check_value("lsu_o.req", lsu_o.req, exp_req);
    check_value("id_in_ready_o", id_in_ready_o, !exp_req);

    if (exp_req) begin
      check_value("lsu_o.we", lsu_o.we, exp_we);
      check_value("lsu_o.data_type", lsu_o.data_type, size_from_funct3(instr[13:12]));
      if (exp_we) begin
        check_value("lsu_o.wdata", lsu_o.wdata, exp_wdata);
      end else begin
        // Only LBU and LHU zero-extend
        check_value("lsu_o.sign_ext", lsu_o.sign_ext, !instr[14]);
      end
      // Memory answers 1 to 4 cycles later
      latency = 1 + ($unsigned($random(seed)) % 4);
      cycles  = 0;
      while (!id_in_ready_o) begin
        @(negedge clk_i);
        instr_new_i = 1'b0;
        cycles++;
        if (cycles == latency) begin
          lsu_valid_i         = 1'b1;
          regfile_wdata_lsu_i = wb_val;
          // Execute side holds other data so only the LSU path reaches the register
          regfile_wdata_ex_i  = ~wb_val;
        end
        #(CLK_PERIOD/4);
        check_value("held lsu_o.req", lsu_o.req, 1'b1);
        if (cycles > TIMEOUT_CYCLES) begin
          abort_run("Timeout: id_in_ready_o never rose while waiting for the memory access");
        end
      end
      check_value("cycles until ready", cycles, latency);
    end

    @(negedge clk_i);
    instr_new_i = 1'b0;
    lsu_valid_i = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    clk_i               = 1'b0;
    rst_ni              = 1'b0;
    instr_new_i         = 1'b0;
    instr_rdata_i       = '0;
    pc_id_i             = '0;
    lsu_valid_i         = 1'b0;
    regfile_wdata_ex_i  = '0;
    regfile_wdata_lsu_i = '0;
    seed                = 32'h271e;

    $readmemh("sim/id_testdata.mem", vec_mem);
    if ($isunknown(vec_mem[NUM_VECS*VEC_WORDS-1])) begin
      abort_run("Could not read all test vectors from sim/id_testdata.mem");
    end

    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    #(CLK_PERIOD/4);
    check_value("id_in_ready_o after reset", id_in_ready_o, 1'b1);
    check_value("lsu_o.req after reset", lsu_o.req, 1'b0);

    for (int unsigned v = 0; v < NUM_VECS; v++) begin
      run_vector(v);
    end

    repeat (2) @(negedge clk_i);
    if (id_stage_i.assertions_i.failures == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      abort_run("One or more bound assertions failed during the run");
    end
  end

endmodule

`default_nettype wire
